// ==== verilog/fxp_format_pkg.sv ====
`default_nettype none

package fxp_format_pkg;

  // Q format shared by operands and result
  localparam int WIDTH = 16;
  localparam int FRAC_BITS = 14;

  // sign bit stripped
  localparam int MAG_WIDTH = WIDTH - 1;

  // divider always runs at least one fractional step
  localparam int FRAC_STEPS = (FRAC_BITS == 0) ? 1 : FRAC_BITS;
  localparam int DIV_ITERS = MAG_WIDTH + FRAC_STEPS;

  // leading quotient bits that must stay zero for the result to fit
  localparam int DIV_OVF_STEPS = DIV_ITERS - MAG_WIDTH;
  localparam int DIV_CNT_WIDTH = $clog2(DIV_ITERS);

  // full product and its width once the fraction is dropped
  localparam int PROD_WIDTH = 2 * WIDTH;
  localparam int TRUNC_WIDTH = PROD_WIDTH - FRAC_BITS;

  // no positive counterpart, so the divider refuses it
  localparam logic [WIDTH-1:0] MOST_NEG = {1'b1, {MAG_WIDTH{1'b0}}};

endpackage

`default_nettype wire

// ==== verilog/fxp_op_pkg.sv ====
`default_nettype none

package fxp_op_pkg;

  // op_in encoding
  localparam logic OP_MUL = 1'b0;
  localparam logic OP_DIV = 1'b1;

  // status word layout
  localparam int STATUS_WIDTH = 2;
  localparam int FLAG_ZERODIV = 0;   // divisor was zero
  localparam int FLAG_OVERFLOW = 1;  // result out of range, forced to 0

endpackage

`default_nettype wire

// ==== verilog/fxp_div.sv ====
`timescale 1ns/100ps
`default_nettype none

module fxp_div (
  input  wire                                    clk_in,
  input  wire                                    rst_in,
  input  wire                                    start,
  input  wire signed [fxp_format_pkg::WIDTH-1:0] a,
  input  wire signed [fxp_format_pkg::WIDTH-1:0] b,
  output logic                                   done,
  output logic                                   busy,
  output logic                                   valid,
  output logic                                   zerodiv,
  output logic                                   overflow,
  output logic signed [fxp_format_pkg::WIDTH-1:0] q
);
  import fxp_format_pkg::*;

  logic [MAG_WIDTH-1:0]     a_abs;
  logic [MAG_WIDTH-1:0]     b_abs;
  logic [MAG_WIDTH-1:0]     a_mag;
  logic [MAG_WIDTH-1:0]     b_mag;
  logic                     neg;       // result sign
  logic [MAG_WIDTH-1:0]     rem;
  logic [MAG_WIDTH-1:0]     rem_next;
  logic [DIV_ITERS-1:0]     qsh;       // dividend bits out, quotient bits in
  logic [DIV_ITERS-1:0]     qsh_next;
  logic [MAG_WIDTH:0]       trial;
  logic [MAG_WIDTH:0]       diff;
  logic                     step_bit;
  logic [DIV_CNT_WIDTH-1:0] cnt;

  enum logic [2:0] {
    st_idle,
    st_init,
    st_calc,
    st_round,
    st_sign
  } state;

  // operand magnitudes, most negative code is caught before use
  always_comb begin
    a_abs = a[WIDTH-1] ? MAG_WIDTH'(-a) : a[MAG_WIDTH-1:0];
    b_abs = b[WIDTH-1] ? MAG_WIDTH'(-b) : b[MAG_WIDTH-1:0];
  end

  // one restoring step
  // in st_round the bit shifted in is the first quotient bit, known to be 0,
  // so the same step yields the rounding bit and the sticky remainder
  always_comb begin
    trial    = {rem, qsh[DIV_ITERS-1]};
    diff     = trial - {1'b0, b_mag};
    step_bit = (trial >= {1'b0, b_mag});
    rem_next = step_bit ? diff[MAG_WIDTH-1:0] : trial[MAG_WIDTH-1:0];
    qsh_next = {qsh[DIV_ITERS-2:0], step_bit};
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state    <= st_idle;
      done     <= 1'b0;
      busy     <= 1'b0;
      valid    <= 1'b0;
      zerodiv  <= 1'b0;
      overflow <= 1'b0;
    end else begin
      done <= 1'b0;  // single cycle pulse
      case (state)
        st_idle: begin
          if (start) begin
            valid <= 1'b0;
            if (b == '0) begin
              zerodiv  <= 1'b1;
              overflow <= 1'b0;
              done     <= 1'b1;
              q        <= '0;
            end else if (a == MOST_NEG || b == MOST_NEG) begin
              zerodiv  <= 1'b0;
              overflow <= 1'b1;
              done     <= 1'b1;
              q        <= '0;
            end else begin
              zerodiv  <= 1'b0;
              overflow <= 1'b0;
              busy     <= 1'b1;
              a_mag    <= a_abs;
              b_mag    <= b_abs;
              neg      <= a[WIDTH-1] ^ b[WIDTH-1];
              state    <= st_init;
            end
          end
        end

        st_init: begin
          // dividend scaled by 2^FRAC_BITS
          rem   <= '0;
          qsh   <= DIV_ITERS'(a_mag) << FRAC_BITS;
          cnt   <= '0;
          state <= st_calc;
        end

        st_calc: begin
          if (step_bit && cnt < DIV_OVF_STEPS) begin
            // integer bit beyond the format, stop here
            overflow <= 1'b1;
            done     <= 1'b1;
            busy     <= 1'b0;
            q        <= '0;
            state    <= st_idle;
          end else begin
            rem <= rem_next;
            qsh <= qsh_next;
            cnt <= cnt + 1'b1;
            if (cnt == DIV_CNT_WIDTH'(DIV_ITERS - 1)) begin
              state <= st_round;
            end
          end
        end

        st_round: begin
          // half to even, ties go up only from an odd lsb
          if (step_bit && (rem_next != '0 || qsh[0])) begin
            qsh[MAG_WIDTH:0] <= qsh[MAG_WIDTH:0] + 1'b1;
          end
          state <= st_sign;
        end

        st_sign: begin
          done  <= 1'b1;
          busy  <= 1'b0;
          state <= st_idle;
          if (qsh[MAG_WIDTH]) begin  // rounding carried out of range
            overflow <= 1'b1;
            q        <= '0;
          end else begin
            valid <= 1'b1;
            q     <= neg ? -$signed({1'b0, qsh[MAG_WIDTH-1:0]})
                         : $signed({1'b0, qsh[MAG_WIDTH-1:0]});
          end
        end

        default: state <= st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/fxp_mul.sv ====
`timescale 1ns/100ps
`default_nettype none

module fxp_mul (
  input  wire                                    clk_in,
  input  wire                                    rst_in,
  input  wire                                    start,
  input  wire signed [fxp_format_pkg::WIDTH-1:0] a,
  input  wire signed [fxp_format_pkg::WIDTH-1:0] b,
  output logic                                   done,
  output logic                                   overflow,
  output logic signed [fxp_format_pkg::WIDTH-1:0] p
);
  import fxp_format_pkg::*;

  // stage one
  logic signed [PROD_WIDTH-1:0]  prod;
  logic                          prod_valid;

  // stage two, combinational part
  logic signed [TRUNC_WIDTH-1:0] trunc;
  logic [FRAC_BITS-1:0]          frac;
  logic [FRAC_BITS-1:0]          frac_low;
  logic                          round_bit;
  logic                          sticky;
  logic                          round_up;
  logic signed [TRUNC_WIDTH-1:0] rounded;
  logic [TRUNC_WIDTH-WIDTH:0]    upper;
  logic                          fits;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      prod_valid <= 1'b0;
    end else begin
      prod_valid <= start;
    end
  end

  // full product, no reset on payload
  always_ff @(posedge clk_in) begin
    if (start) begin
      prod <= a * b;
    end
  end

  // trunc is the floor of the scaled value, frac what lies below it
  always_comb begin
    trunc     = prod[PROD_WIDTH-1:FRAC_BITS];
    frac      = prod[FRAC_BITS-1:0];
    round_bit = frac[FRAC_BITS-1];
    frac_low  = frac << 1;
    sticky    = |frac_low;
    round_up  = round_bit && (sticky || trunc[0]);  // half to even
    rounded   = trunc + TRUNC_WIDTH'(round_up);
  end

  // discarded high bits must all repeat the result sign
  always_comb begin
    upper = rounded[TRUNC_WIDTH-1:WIDTH-1];
    fits  = (&upper) | ~(|upper);
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      done <= 1'b0;
    end else begin
      done <= prod_valid;
    end
  end

  always_ff @(posedge clk_in) begin
    if (prod_valid) begin
      overflow <= ~fits;
      p        <= fits ? rounded[WIDTH-1:0] : '0;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/fxp_math_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module fxp_math_unit (
  input  wire                                      clk_in,
  input  wire                                      rst_in,
  input  wire                                      valid_in,
  input  wire                                      op_in,
  input  wire signed [fxp_format_pkg::WIDTH-1:0]   a_in,
  input  wire signed [fxp_format_pkg::WIDTH-1:0]   b_in,
  output logic                                     busy,
  output logic                                     done,
  output logic signed [fxp_format_pkg::WIDTH-1:0]  result,
  output logic [fxp_op_pkg::STATUS_WIDTH-1:0]      status,
  output logic                                     ok
);
  import fxp_format_pkg::*;
  import fxp_op_pkg::*;

  logic                    accept;
  logic                    mul_start;
  logic                    div_start;
  logic                    mul_hold;
  logic [1:0]              mul_cnt;  // multiplies in flight, at most 2

  logic                    div_done;
  logic                    div_busy;
  logic                    div_valid;
  logic                    div_zerodiv;
  logic                    div_overflow;
  logic signed [WIDTH-1:0] div_q;

  logic                    mul_done;
  logic                    mul_overflow;
  logic signed [WIDTH-1:0] mul_p;

  // a divide waits until the multiplier drains so the dones never collide
  assign mul_hold  = (mul_cnt != 2'd0) && valid_in && (op_in == OP_DIV);
  assign busy      = div_busy | div_done | mul_hold;
  assign accept    = valid_in & ~busy;
  assign mul_start = accept && (op_in == OP_MUL);
  assign div_start = accept && (op_in == OP_DIV);

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      mul_cnt <= 2'd0;
    end else begin
      case ({mul_start, mul_done})
        2'b10:   mul_cnt <= mul_cnt + 2'd1;
        2'b01:   mul_cnt <= mul_cnt - 2'd1;
        default: mul_cnt <= mul_cnt;  // none or both
      endcase
    end
  end

  fxp_div u_div (
    .clk_in   (clk_in),
    .rst_in   (rst_in),
    .start    (div_start),
    .a        (a_in),
    .b        (b_in),
    .done     (div_done),
    .busy     (div_busy),
    .valid    (div_valid),
    .zerodiv  (div_zerodiv),
    .overflow (div_overflow),
    .q        (div_q)
  );

  fxp_mul u_mul (
    .clk_in   (clk_in),
    .rst_in   (rst_in),
    .start    (mul_start),
    .a        (a_in),
    .b        (b_in),
    .done     (mul_done),
    .overflow (mul_overflow),
    .p        (mul_p)
  );

  // result merge, only one engine can finish per cycle
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      done   <= 1'b0;
      result <= '0;
      status <= '0;
      ok     <= 1'b0;
    end else begin
      done <= mul_done | div_done;
      if (mul_done) begin
        result                <= mul_p;
        status[FLAG_ZERODIV]  <= 1'b0;
        status[FLAG_OVERFLOW] <= mul_overflow;
        ok                    <= ~mul_overflow;
      end else if (div_done) begin
        result                <= div_q;
        status[FLAG_ZERODIV]  <= div_zerodiv;
        status[FLAG_OVERFLOW] <= div_overflow;
        ok                    <= div_valid;
      end
    end
  end

endmodule

`default_nettype wire

// ==== dv/fxp_math_unit_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

module fxp_math_unit_sva (
  input wire                                 clk_in,
  input wire                                 rst_in,
  input wire                                 busy,
  input wire                                 done,
  input wire                                 ok,
  input wire [fxp_op_pkg::STATUS_WIDTH-1:0]  status,
  input wire                                 div_done,
  input wire                                 mul_done
);
  import fxp_op_pkg::*;

  // one divide gives one engine pulse and one top pulse
  assert property (@(posedge clk_in) disable iff (rst_in)
    div_done |=> !div_done)
    else $error("divider done held high for two cycles");

  assert property (@(posedge clk_in) disable iff (rst_in)
    (done && $past(div_done)) |=> !done)
    else $error("top done repeated after a single divide");

  // busy only drops as a result leaves the top
  assert property (@(posedge clk_in) disable iff (rst_in)
    $fell(busy) |-> done)
    else $error("busy released without a matching done");

  // a zero divide never counts as a good result
  assert property (@(posedge clk_in) disable iff (rst_in)
    (done && status[FLAG_ZERODIV]) |-> !ok)
    else $error("zero divide reported with ok high");

  // both engines must never finish together
  assert property (@(posedge clk_in) disable iff (rst_in)
    !(div_done && mul_done))
    else $error("divider and multiplier finished in the same cycle");

  // clean outputs right after reset
  assert property (@(posedge clk_in)
    $fell(rst_in) |-> (!busy && !done))
    else $error("busy or done high in the first cycle after reset");

endmodule

`default_nettype wire

// ==== dv/fxp_math_unit_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module fxp_math_unit_tb;
  import fxp_format_pkg::*;
  import fxp_op_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int N_REQ = 120;           // upper bound on issued requests
  localparam int MUL_LAT = 3;           // presented cycle to top done
  localparam int DIV_LAT = DIV_ITERS + 5;

  logic                    clk_in;
  logic                    rst_in;
  logic                    valid_in;
  logic                    op_in;
  logic signed [WIDTH-1:0] a_in;
  logic signed [WIDTH-1:0] b_in;
  logic                    busy;
  logic                    done;
  logic signed [WIDTH-1:0] result;
  logic [STATUS_WIDTH-1:0] status;
  logic                    ok;

  logic [31:0] lcg_state;
  int          cyc;
  int          value_errors;
  int          protocol_errors;
  int          n_done;

  // scoreboard, one entry per accepted request
  logic signed [WIDTH-1:0] exp_result[$];
  logic [STATUS_WIDTH-1:0] exp_status[$];
  logic                    exp_ok[$];
  int                      exp_lat[$];  // 0 means latency not checked
  int                      acc_cyc[$];
  string                   exp_name[$];

  fxp_math_unit dut (
    .clk_in   (clk_in),
    .rst_in   (rst_in),
    .valid_in (valid_in),
    .op_in    (op_in),
    .a_in     (a_in),
    .b_in     (b_in),
    .busy     (busy),
    .done     (done),
    .result   (result),
    .status   (status),
    .ok       (ok)
  );

  bind fxp_math_unit fxp_math_unit_sva u_sva (
    .clk_in   (clk_in),
    .rst_in   (rst_in),
    .busy     (busy),
    .done     (done),
    .ok       (ok),
    .status   (status),
    .div_done (div_done),
    .mul_done (mul_done)
  );

  initial clk_in = 1'b0;
  always #(CLK_PERIOD / 2) clk_in = ~clk_in;

  always @(posedge clk_in) cyc = cyc + 1;  // read only on falling edges

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic longint mag(input logic signed [WIDTH-1:0] v);
    return (v < 0) ? -longint'(v) : longint'(v);
  endfunction

  // reference model in wide integers
  task automatic model(input logic op, input logic signed [WIDTH-1:0] a,
                       input logic signed [WIDTH-1:0] b,
                       output logic signed [WIDTH-1:0] r,
                       output logic [STATUS_WIDTH-1:0] st, output logic k,
                       output int lat);
    longint p;
    longint fl;
    longint fr;
    longint half;
    longint lim;
    longint num;
    logic   neg;
    lim = longint'(1) << MAG_WIDTH;
    r   = '0;
    st  = '0;
    k   = 1'b0;
    lat = 0;
    if (op == OP_MUL) begin
      p    = longint'(a) * longint'(b);
      fl   = p >>> FRAC_BITS;  // floor
      fr   = p - (fl <<< FRAC_BITS);
      half = longint'(1) << (FRAC_BITS - 1);
      if (fr > half || (fr == half && fl[0])) fl = fl + 1;
      lat = MUL_LAT;
      if (fl >= lim || fl < -lim) begin
        st[FLAG_OVERFLOW] = 1'b1;
      end else begin
        r = WIDTH'(fl);
        k = 1'b1;
      end
    end else if (b == 0) begin
      st[FLAG_ZERODIV] = 1'b1;
    end else if (a == MOST_NEG || b == MOST_NEG) begin
      st[FLAG_OVERFLOW] = 1'b1;
    end else begin
      neg = a[WIDTH-1] ^ b[WIDTH-1];
      num = mag(a) << FRAC_BITS;
      fl  = num / mag(b);
      fr  = num % mag(b);
      if (2 * fr > mag(b) || (2 * fr == mag(b) && fl[0])) fl = fl + 1;
      if (fl >= lim) begin
        st[FLAG_OVERFLOW] = 1'b1;  // early exit, timing not fixed
      end else begin
        r   = neg ? WIDTH'(-fl) : WIDTH'(fl);
        k   = 1'b1;
        lat = DIV_LAT;
      end
    end
  endtask

  // keeps the request up until busy lets it through
  task automatic issue(input logic op, input logic signed [WIDTH-1:0] a,
                       input logic signed [WIDTH-1:0] b, input string name);
    logic signed [WIDTH-1:0] r;
    logic [STATUS_WIDTH-1:0] st;
    logic                    k;
    int                      lat;
    @(negedge clk_in);
    valid_in = 1'b1;
    op_in    = op;
    a_in     = a;
    b_in     = b;
    #1;
    while (busy) begin
      @(negedge clk_in);
      #1;
    end
    model(op, a, b, r, st, k, lat);
    exp_result.push_back(r);
    exp_status.push_back(st);
    exp_ok.push_back(k);
    exp_lat.push_back(lat);
    acc_cyc.push_back(cyc);
    exp_name.push_back(name);
    @(posedge clk_in);
  endtask

  // gives up after the longest possible latency
  task automatic drain();
    int n;
    n = 0;
    @(negedge clk_in);
    valid_in = 1'b0;
    while (exp_result.size() != 0 && n < DIV_LAT + 8) begin
      @(negedge clk_in);
      n++;
    end
    repeat (2) @(negedge clk_in);
  endtask

  always @(negedge clk_in) begin
    if (!rst_in && done) begin
      n_done++;
      if (exp_result.size() == 0) begin
        protocol_errors++;
        $display("done pulse seen with no request outstanding");
      end else begin
        assert (result == exp_result[0]) else begin
          value_errors++;
          $display("FAILED %s result: expected %0d, got %0d",
                   exp_name[0], exp_result[0], result);
        end
        assert (status == exp_status[0]) else begin
          value_errors++;
          $display("FAILED %s status: expected %b, got %b",
                   exp_name[0], exp_status[0], status);
        end
        assert (ok == exp_ok[0]) else begin
          value_errors++;
          $display("FAILED %s ok: expected %b, got %b", exp_name[0], exp_ok[0], ok);
        end
        assert (exp_lat[0] == 0 || cyc - acc_cyc[0] == exp_lat[0]) else begin
          value_errors++;
          $display("FAILED %s latency: expected %0d, got %0d",
                   exp_name[0], exp_lat[0], cyc - acc_cyc[0]);
        end
        void'(exp_result.pop_front());
        void'(exp_status.pop_front());
        void'(exp_ok.pop_front());
        void'(exp_lat.pop_front());
        void'(acc_cyc.pop_front());
        void'(exp_name.pop_front());
      end
    end
  end

  initial begin
    #(CLK_PERIOD * (N_REQ * (DIV_ITERS + 8) + 100));
    $display("watchdog expired before all results came back");
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    logic [31:0]             ra;
    logic [31:0]             rb;
    logic signed [WIDTH-1:0] x;
    logic signed [WIDTH-1:0] y;
    logic signed [WIDTH-1:0] t;
    int                      i;
    lcg_state       = 32'h370aa654;
    cyc             = 0;
    value_errors    = 0;
    protocol_errors = 0;
    n_done          = 0;
    rst_in   = 1'b1;
    valid_in = 1'b0;
    op_in    = 1'b0;
    a_in     = '0;
    b_in     = '0;
    repeat (3) @(posedge clk_in);
    @(negedge clk_in);
    rst_in = 1'b0;

    for (i = 0; i < 40; i++) begin  // back to back products
      ra = lcg_next();
      rb = lcg_next();
      issue(OP_MUL, ra[31:16], rb[31:16], "mul_random");
    end
    // exact halves, even and odd neighbours
    issue(OP_MUL, 16'sd1, 16'sd8192, "mul_tie_down");
    issue(OP_MUL, 16'sd3, 16'sd8192, "mul_tie_up");
    issue(OP_MUL, -16'sd1, 16'sd8192, "mul_tie_neg");
    issue(OP_MUL, 16'sd5, 16'sd8192, "mul_tie_even");
    drain();

    for (i = 0; i < 30; i++) begin
      ra = lcg_next();
      rb = lcg_next();
      x  = ra[31:16];
      y  = rb[31:16];
      if (x == MOST_NEG) x = x + 1;
      if (y == MOST_NEG) y = y + 1;
      if (mag(x) > mag(y)) begin  // keeps the quotient in range
        t = x;
        x = y;
        y = t;
      end
      if (y == 0) y = 16'sd1;
      issue(OP_DIV, x, y, "div_random");
    end
    drain();

    issue(OP_DIV, 16'sd100, 16'sd0, "div_zero");
    issue(OP_DIV, -16'sd5, 16'sd0, "div_zero_neg");
    issue(OP_DIV, MOST_NEG, 16'sd3, "div_most_neg_a");
    issue(OP_DIV, 16'sd7, MOST_NEG, "div_most_neg_b");
    issue(OP_DIV, 16'sd32767, 16'sd1, "div_ovf_big");
    issue(OP_DIV, -16'sd20000, 16'sd3, "div_ovf_neg");
    issue(OP_DIV, 16'sd16384, 16'sd8191, "div_ovf_edge");
    issue(OP_DIV, 16'sd8192, 16'sd16384, "div_after_ovf");
    drain();

    for (i = 0; i < 16; i++) begin  // request order across engines
      ra = lcg_next();
      rb = lcg_next();
      issue(ra[3] ? OP_DIV : OP_MUL, ra[31:16], rb[31:16], "mixed");
    end
    drain();

    if (exp_result.size() != 0) begin
      protocol_errors++;
      $display("%0d expected results never came back", exp_result.size());
    end
    $display("value errors: %0d, protocol errors: %0d, done pulses: %0d",
             value_errors, protocol_errors, n_done);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
verilog/fxp_format_pkg.sv
verilog/fxp_op_pkg.sv
verilog/fxp_div.sv
verilog/fxp_mul.sv
verilog/fxp_math_unit.sv
dv/fxp_math_unit_sva.sv
dv/fxp_math_unit_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= fxp_math_unit_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= SOME TESTS FAILED
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	test $$status -eq 0 && ! grep -q "$(FAIL_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
